// File: compile.f
tlb_pkg.sv
tlb_l1_lookup.sv
tlb_addr_rewrite.sv
tlb_resp_merge.sv
tlb_xlate_top.sv
tlb_xlate_props.sv
tb_tlb_xlate.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the translation unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_tlb_xlate \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// File: tb_tlb_xlate.sv
// Testbench for tlb_xlate_top: stimulus table, memory model, LFSR, checks and closing line
`timescale 1ns/1ps

module tb_tlb_xlate import tlb_pkg::*; ();

  localparam int NUM_ROWS = 13;
  localparam int TIMEOUT  = 500;

  typedef struct packed {
    logic                  bypass;
    logic [ID_W-1:0]       id;
    logic [IN_ADDR_W-1:0]  addr;
    logic                  write;
    logic [DATA_W-1:0]     wdata;
    logic                  hit;
    logic [OUT_ADDR_W-1:0] xaddr;
  } row_t;

  logic                         clk = 1'b0;
  logic                         rst_n;
  tlb_entry_t [NUM_ENTRIES-1:0] entries;
  logic                         bypass;
  xlate_req_t                   slv_req;
  logic                         slv_req_valid;
  logic                         slv_req_ready;
  xlate_resp_t                  slv_resp;
  logic                         slv_resp_valid;
  logic                         slv_resp_ready = 1'b0;
  mst_req_t                     mst_req;
  logic                         mst_req_valid;
  logic                         mst_req_ready = 1'b0;
  xlate_resp_t                  mst_resp = '0;
  logic                         mst_resp_valid = 1'b0;
  logic                         mst_resp_ready;

  row_t        rows [NUM_ROWS];
  string       row_name [NUM_ROWS];
  int          n_rows;
  int          resp_count [NUM_ROWS];
  int          resp_total;
  int          errors;
  logic [31:0] lfsr_state = 32'h1d235a7b;
  xlate_resp_t pend_resp [$];
  int          pend_dly [$];

  always #5 clk = ~clk;

  tlb_xlate_top uut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .entries_i        (entries),
    .bypass_i         (bypass),
    .slv_req_i        (slv_req),
    .slv_req_valid_i  (slv_req_valid),
    .slv_req_ready_o  (slv_req_ready),
    .slv_resp_o       (slv_resp),
    .slv_resp_valid_o (slv_resp_valid),
    .slv_resp_ready_i (slv_resp_ready),
    .mst_req_o        (mst_req),
    .mst_req_valid_o  (mst_req_valid),
    .mst_req_ready_i  (mst_req_ready),
    .mst_resp_i       (mst_resp),
    .mst_resp_valid_i (mst_resp_valid),
    .mst_resp_ready_o (mst_resp_ready)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic tlb_entry_t make_entry(input logic v, input logic [IN_PAGE_W-1:0] first,
                                            input logic [IN_PAGE_W-1:0] last,
                                            input logic [OUT_PAGE_W-1:0] base);
    tlb_entry_t e;
    e.valid      = v;
    e.first_page = first;
    e.last_page  = last;
    e.base_page  = base;
    return e;
  endfunction

  task automatic add_row(input string name, input logic byp, input logic [ID_W-1:0] id,
                         input logic [IN_ADDR_W-1:0] addr, input logic wr,
                         input logic [DATA_W-1:0] wdata, input logic hit,
                         input logic [OUT_ADDR_W-1:0] xaddr);
    row_name[n_rows]     = name;
    rows[n_rows].bypass  = byp;
    rows[n_rows].id      = id;
    rows[n_rows].addr    = addr;
    rows[n_rows].write   = wr;
    rows[n_rows].wdata   = wdata;
    rows[n_rows].hit     = hit;
    rows[n_rows].xaddr   = xaddr;
    n_rows++;
  endtask

  task automatic check(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp_v, act_v);
    end
  endtask

  function automatic int find_row(input logic [ID_W-1:0] id);
    for (int i = 0; i < n_rows; i++) begin
      if (rows[i].id == id) return i;
    end
    return -1;
  endfunction

  // Error responses carry dec0ffee, memory data is address low word XOR write data
  function automatic logic [DATA_W-1:0] exp_rdata(input int r);
    if (!rows[r].hit) return 32'hdec0ffee;
    return rows[r].xaddr[31:0] ^ (rows[r].write ? rows[r].wdata : 32'h0);
  endfunction

  // Memory model with throttled readies and a 0 to 3 cycle answer delay
  always @(posedge clk) begin : mem_model
    xlate_resp_t resp;
    logic        done;
    int          dly;
    if (!rst_n) begin
      mst_req_ready  <= 1'b0;
      slv_resp_ready <= 1'b0;
      mst_resp_valid <= 1'b0;
    end else begin
      done = mst_resp_valid && mst_resp_ready;
      if (done) begin
        void'(pend_resp.pop_front());
        void'(pend_dly.pop_front());
      end
      if (mst_req_valid && mst_req_ready) begin
        resp.id    = mst_req.id;
        resp.rdata = mst_req.addr[31:0] ^ (mst_req.write ? mst_req.wdata : 32'h0);
        resp.err   = 1'b0;
        dly = lfsr_bit() ? 2 : 0;
        if (lfsr_bit()) dly = dly + 1;
        pend_resp.push_back(resp);
        pend_dly.push_back(dly);
      end
      // Oldest answer goes out once its delay has run down
      if (pend_resp.size() > 0 && (done || !mst_resp_valid)) begin
        if (pend_dly[0] == 0) begin
          mst_resp       <= pend_resp[0];
          mst_resp_valid <= 1'b1;
        end else begin
          pend_dly[0]    = pend_dly[0] - 1;
          mst_resp_valid <= 1'b0;
        end
      end else if (done) begin
        mst_resp_valid <= 1'b0;
      end
      mst_req_ready  <= lfsr_bit();
      slv_resp_ready <= lfsr_bit();
    end
  end

  always @(posedge clk) begin : monitor
    int r;
    if (rst_n) begin
      if (mst_req_valid && mst_req_ready) begin
        r = find_row(mst_req.id);
        if (r < 0) begin
          errors++;
          $display("Master request with unknown ID %0d", mst_req.id);
        end else if (!rows[r].hit) begin
          errors++;
          $display("Request %s should miss but reached the master port", row_name[r]);
        end else begin
          check({row_name[r], " addr"}, 64'(rows[r].xaddr), 64'(mst_req.addr));
          check({row_name[r], " write"}, 64'(rows[r].write), 64'(mst_req.write));
          check({row_name[r], " wdata"}, 64'(rows[r].wdata), 64'(mst_req.wdata));
        end
      end
      if (slv_resp_valid && slv_resp_ready) begin
        r = find_row(slv_resp.id);
        if (r < 0) begin
          errors++;
          $display("Slave response with unknown ID %0d", slv_resp.id);
        end else begin
          resp_count[r]++;
          resp_total++;
          check({row_name[r], " err"}, 64'(!rows[r].hit), 64'(slv_resp.err));
          check({row_name[r], " rdata"}, 64'(exp_rdata(r)), 64'(slv_resp.rdata));
        end
      end
    end
  end

  initial begin : stimulus
    int waited;
    rst_n         = 1'b0;
    bypass        = 1'b0;
    slv_req       = '0;
    slv_req_valid = 1'b0;
    entries[0] = make_entry(1'b1, 20'h00010, 20'h0001f, 24'h080000);
    entries[1] = make_entry(1'b1, 20'h00018, 20'h0002f, 24'h000003);
    entries[2] = make_entry(1'b0, 20'h00040, 20'h0004f, 24'h000500);
    entries[3] = make_entry(1'b1, 20'h00100, 20'h00100, 24'h123456);
    // name, bypass, id, addr, write, wdata, hit, translated address
    add_row("e0_low",    1'b0, 4'd0,  32'h00010abc, 1'b0, 32'h00000000, 1'b1, 36'h080000abc);
    add_row("e0_write",  1'b0, 4'd1,  32'h00015123, 1'b1, 32'ha5a5a5a5, 1'b1, 36'h080005123);
    add_row("overlap",   1'b0, 4'd2,  32'h0001c7f0, 1'b0, 32'h00000000, 1'b1, 36'h08000c7f0);
    add_row("e1_only",   1'b0, 4'd3,  32'h00024008, 1'b1, 32'h12345678, 1'b1, 36'h00000f008);
    add_row("e3_page",   1'b0, 4'd4,  32'h00100ffc, 1'b0, 32'h00000000, 1'b1, 36'h123456ffc);
    add_row("e2_invalid", 1'b0, 4'd5, 32'h00044000, 1'b0, 32'h00000000, 1'b0, 36'h0);
    add_row("far_miss",  1'b0, 4'd6,  32'hdeadbeef, 1'b1, 32'hcafef00d, 1'b0, 36'h0);
    add_row("byp_miss",  1'b1, 4'd7,  32'h00044abc, 1'b0, 32'h00000000, 1'b1, 36'h000044abc);
    add_row("byp_high",  1'b1, 4'd8,  32'hfffff000, 1'b1, 32'h0f0f0f0f, 1'b1, 36'h0fffff000);
    add_row("page_zero", 1'b0, 4'd9,  32'h00000123, 1'b0, 32'h00000000, 1'b0, 36'h0);
    add_row("e0_last",   1'b0, 4'd10, 32'h0001f000, 1'b1, 32'h55aa55aa, 1'b1, 36'h08000f000);
    add_row("e3_next",   1'b0, 4'd11, 32'h00101000, 1'b0, 32'h00000000, 1'b0, 36'h0);
    add_row("byp_e0",    1'b1, 4'd12, 32'h00012345, 1'b0, 32'h00000000, 1'b1, 36'h000012345);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int r = 0; r < n_rows; r++) begin
      bypass        <= rows[r].bypass;
      slv_req.id    <= rows[r].id;
      slv_req.addr  <= rows[r].addr;
      slv_req.write <= rows[r].write;
      slv_req.wdata <= rows[r].wdata;
      slv_req_valid <= 1'b1;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
      end while (!slv_req_ready && waited < TIMEOUT);
      if (!slv_req_ready) begin
        errors++;
        $display("Timeout: request %s was never accepted", row_name[r]);
        break;
      end
    end
    slv_req_valid <= 1'b0;
    waited = 0;
    while (resp_total < n_rows && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (resp_total < n_rows) begin
      errors++;
      $display("Timeout: only %0d of %0d responses arrived", resp_total, n_rows);
    end
    // Idle cycles so that a late duplicate still gets counted
    repeat (20) @(posedge clk);
    for (int r = 0; r < n_rows; r++) begin
      check({row_name[r], " responses"}, 64'd1, 64'(resp_count[r]));
    end
    errors = errors + uut.u_props.fail_cnt;
    $display("Closing: %0d errors, %0d responses", errors, resp_total);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: tlb_addr_rewrite.sv
// Rewrite stage: hits go to the master port with the new address, misses to the miss output
`timescale 1ns/1ps

module tlb_addr_rewrite import tlb_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  lookup_t    lk_i,
  input  logic       lk_valid_i,
  output logic       lk_ready_o,
  output mst_req_t   mst_req_o,
  output logic       mst_req_valid_o,
  input  logic       mst_req_ready_i,
  output xlate_req_t miss_o,
  output logic       miss_valid_o,
  input  logic       miss_ready_i
);

  lookup_t item_q;
  logic    mst_valid_q;
  logic    miss_valid_q;
  logic    item_leaves;
  logic    accept;

  // Only one of the two valids is ever set for the held item
  assign item_leaves = (mst_valid_q && mst_req_ready_i) || (miss_valid_q && miss_ready_i);
  assign lk_ready_o  = !(mst_valid_q || miss_valid_q) || item_leaves;
  assign accept      = lk_valid_i && lk_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mst_valid_q  <= 1'b0;
      miss_valid_q <= 1'b0;
    end else if (accept) begin
      mst_valid_q  <= lk_i.hit;
      miss_valid_q <= !lk_i.hit;
    end else if (item_leaves) begin
      mst_valid_q  <= 1'b0;
      miss_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      item_q <= lk_i;
    end
  end

  // Master request keeps id, write and data but takes the translated address
  assign mst_req_o.id    = item_q.req.id;
  assign mst_req_o.addr  = item_q.addr;
  assign mst_req_o.write = item_q.req.write;
  assign mst_req_o.wdata = item_q.req.wdata;
  assign mst_req_valid_o = mst_valid_q;

  assign miss_o       = item_q.req;
  assign miss_valid_o = miss_valid_q;

endmodule

// File: tlb_l1_lookup.sv
// L1 lookup stage: entry match and translated address, registered with the request
`timescale 1ns/1ps

module tlb_l1_lookup import tlb_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  tlb_entry_t [NUM_ENTRIES-1:0] entries_i,
  input  logic                         bypass_i,
  input  xlate_req_t                   slv_req_i,
  input  logic                         slv_req_valid_i,
  output logic                         slv_req_ready_o,
  output lookup_t                      lk_o,
  output logic                         lk_valid_o,
  input  logic                         lk_ready_i
);

  logic                  hit_d;
  logic [OUT_ADDR_W-1:0] addr_d;
  lookup_t               lk_q;
  logic                  valid_q;
  logic                  accept;

  // Combinational match against the whole entry table
  always_comb begin
    hit_d = tlb_translate(slv_req_i.addr, entries_i, bypass_i, addr_d);
  end

  // Free when empty or when the held item leaves this cycle
  assign slv_req_ready_o = !valid_q || lk_ready_i;
  assign accept          = slv_req_valid_i && slv_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (lk_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      lk_q.req  <= slv_req_i;
      lk_q.hit  <= hit_d;
      lk_q.addr <= addr_d;
    end
  end

  assign lk_o       = lk_q;
  assign lk_valid_o = valid_q;

endmodule

// File: tlb_pkg.sv
// Widths, entry and channel structs, and the page translation function
package tlb_pkg;

  localparam int unsigned IN_ADDR_W   = 32;
  localparam int unsigned OUT_ADDR_W  = 36;
  localparam int unsigned PAGE_OFFS_W = 12;
  localparam int unsigned ID_W        = 4;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned NUM_ENTRIES = 4;

  // Page number widths on either side of the unit
  localparam int unsigned IN_PAGE_W  = IN_ADDR_W - PAGE_OFFS_W;
  localparam int unsigned OUT_PAGE_W = OUT_ADDR_W - PAGE_OFFS_W;

  // Read data returned with every error response
  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hdec0ffee;

  typedef struct packed {
    logic                  valid;
    logic [IN_PAGE_W-1:0]  first_page;
    logic [IN_PAGE_W-1:0]  last_page;
    logic [OUT_PAGE_W-1:0] base_page;
  } tlb_entry_t;

  typedef struct packed {
    logic [ID_W-1:0]      id;
    logic [IN_ADDR_W-1:0] addr;
    logic                 write;
    logic [DATA_W-1:0]    wdata;
  } xlate_req_t;

  typedef struct packed {
    logic [ID_W-1:0]       id;
    logic [OUT_ADDR_W-1:0] addr;
    logic                  write;
    logic [DATA_W-1:0]     wdata;
  } mst_req_t;

  typedef struct packed {
    xlate_req_t            req;
    logic                  hit;
    logic [OUT_ADDR_W-1:0] addr;
  } lookup_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] rdata;
    logic              err;
  } xlate_resp_t;

  // Returns the hit bit, translated address comes back through out_addr
  function automatic logic tlb_translate(
    input  logic [IN_ADDR_W-1:0]         addr,
    input  tlb_entry_t [NUM_ENTRIES-1:0] entries,
    input  logic                         bypass,
    output logic [OUT_ADDR_W-1:0]        out_addr
  );
    logic [IN_PAGE_W-1:0] page;
    logic                 hit;
    page     = addr[IN_ADDR_W-1:PAGE_OFFS_W];
    hit      = 1'b0;
    out_addr = '0;
    if (bypass) begin
      hit      = 1'b1;
      out_addr = OUT_ADDR_W'(addr);
    end else begin
      // First matching entry wins, so scan upward and stop updating on a hit
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (!hit && entries[i].valid && (page >= entries[i].first_page) &&
            (page <= entries[i].last_page)) begin
          hit      = 1'b1;
          out_addr = {entries[i].base_page + OUT_PAGE_W'(page - entries[i].first_page),
                      addr[PAGE_OFFS_W-1:0]};
        end
      end
    end
    return hit;
  endfunction

endpackage

// File: tlb_resp_merge.sv
// Response merge: one-entry error buffer for misses, muxed with master responses
`timescale 1ns/1ps

module tlb_resp_merge import tlb_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  xlate_req_t  miss_i,
  input  logic        miss_valid_i,
  output logic        miss_ready_o,
  input  xlate_resp_t mst_resp_i,
  input  logic        mst_resp_valid_i,
  output logic        mst_resp_ready_o,
  output xlate_resp_t slv_resp_o,
  output logic        slv_resp_valid_o,
  input  logic        slv_resp_ready_i
);

  logic            err_valid_q;
  logic [ID_W-1:0] err_id_q;
  logic            accept;
  logic            err_leaves;

  assign err_leaves = err_valid_q && slv_resp_ready_i;

  // A master response already on the slave port must not be replaced before
  // it transfers, so a new miss waits while one is shown and stalled
  assign miss_ready_o = slv_resp_ready_i || !(err_valid_q || mst_resp_valid_i);
  assign accept       = miss_valid_i && miss_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_valid_q <= 1'b0;
    end else if (accept) begin
      err_valid_q <= 1'b1;
    end else if (err_leaves) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      err_id_q <= miss_i.id;
    end
  end

  // Waiting error response has priority over the master port
  always_comb begin
    if (err_valid_q) begin
      slv_resp_o.id    = err_id_q;
      slv_resp_o.rdata = ERR_RDATA;
      slv_resp_o.err   = 1'b1;
      slv_resp_valid_o = 1'b1;
      mst_resp_ready_o = 1'b0;
    end else begin
      slv_resp_o       = mst_resp_i;
      slv_resp_valid_o = mst_resp_valid_i;
      mst_resp_ready_o = slv_resp_ready_i;
    end
  end

endmodule

// File: tlb_xlate_props.sv
// Handshake, exclusivity, reset and error response assertions for tlb_xlate_top
`timescale 1ns/1ps

module tlb_xlate_props import tlb_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input lookup_t     lk_i,
  input logic        lk_valid_i,
  input logic        lk_ready_i,
  input xlate_req_t  miss_i,
  input logic        miss_valid_i,
  input logic        miss_ready_i,
  input mst_req_t    mst_req_i,
  input logic        mst_req_valid_i,
  input logic        mst_req_ready_i,
  input xlate_resp_t slv_resp_i,
  input logic        slv_resp_valid_i,
  input logic        slv_resp_ready_i
);

  int fail_cnt = 0;

  a_lk_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lk_valid_i && !lk_ready_i |=> lk_valid_i && $stable(lk_i))
    else begin
      fail_cnt++;
      $error("Lookup output dropped or changed before ready");
    end

  a_mst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_valid_i && !mst_req_ready_i |=> mst_req_valid_i && $stable(mst_req_i))
    else begin
      fail_cnt++;
      $error("Master request dropped or changed before ready");
    end

  a_miss_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    miss_valid_i && !miss_ready_i |=> miss_valid_i && $stable(miss_i))
    else begin
      fail_cnt++;
      $error("Miss dropped or changed before ready");
    end

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_resp_valid_i && !slv_resp_ready_i |=> slv_resp_valid_i && $stable(slv_resp_i))
    else begin
      fail_cnt++;
      $error("Slave response dropped or changed before ready");
    end

  // Both outputs come from the same rewrite register
  a_one_path: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mst_req_valid_i && miss_valid_i))
    else begin
      fail_cnt++;
      $error("Item shown on master port and miss output together");
    end

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> !(lk_valid_i || mst_req_valid_i || miss_valid_i || slv_resp_valid_i))
    else begin
      fail_cnt++;
      $error("Valid output high in the cycle after reset");
    end

  a_err_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_resp_valid_i && slv_resp_i.err |-> slv_resp_i.rdata == 32'hdec0ffee)
    else begin
      fail_cnt++;
      $error("Error response with wrong rdata");
    end

endmodule

bind tlb_xlate_top tlb_xlate_props u_props (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .lk_i             (lk),
  .lk_valid_i       (lk_valid),
  .lk_ready_i       (lk_ready),
  .miss_i           (miss),
  .miss_valid_i     (miss_valid),
  .miss_ready_i     (miss_ready),
  .mst_req_i        (mst_req_o),
  .mst_req_valid_i  (mst_req_valid_o),
  .mst_req_ready_i  (mst_req_ready_i),
  .slv_resp_i       (slv_resp_o),
  .slv_resp_valid_i (slv_resp_valid_o),
  .slv_resp_ready_i (slv_resp_ready_i)
);

// File: tlb_xlate_top.sv
// Top level of the translation unit: lookup, rewrite and response merge stages
`timescale 1ns/1ps

module tlb_xlate_top import tlb_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  tlb_entry_t [NUM_ENTRIES-1:0] entries_i,
  input  logic                         bypass_i,
  // Slave side
  input  xlate_req_t                   slv_req_i,
  input  logic                         slv_req_valid_i,
  output logic                         slv_req_ready_o,
  output xlate_resp_t                  slv_resp_o,
  output logic                         slv_resp_valid_o,
  input  logic                         slv_resp_ready_i,
  // Master side
  output mst_req_t                     mst_req_o,
  output logic                         mst_req_valid_o,
  input  logic                         mst_req_ready_i,
  input  xlate_resp_t                  mst_resp_i,
  input  logic                         mst_resp_valid_i,
  output logic                         mst_resp_ready_o
);

  lookup_t    lk;
  logic       lk_valid;
  logic       lk_ready;
  xlate_req_t miss;
  logic       miss_valid;
  logic       miss_ready;

  tlb_l1_lookup u_lookup (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .entries_i       (entries_i),
    .bypass_i        (bypass_i),
    .slv_req_i       (slv_req_i),
    .slv_req_valid_i (slv_req_valid_i),
    .slv_req_ready_o (slv_req_ready_o),
    .lk_o            (lk),
    .lk_valid_o      (lk_valid),
    .lk_ready_i      (lk_ready)
  );

  tlb_addr_rewrite u_rewrite (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .lk_i            (lk),
    .lk_valid_i      (lk_valid),
    .lk_ready_o      (lk_ready),
    .mst_req_o       (mst_req_o),
    .mst_req_valid_o (mst_req_valid_o),
    .mst_req_ready_i (mst_req_ready_i),
    .miss_o          (miss),
    .miss_valid_o    (miss_valid),
    .miss_ready_i    (miss_ready)
  );

  tlb_resp_merge u_merge (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .miss_i           (miss),
    .miss_valid_i     (miss_valid),
    .miss_ready_o     (miss_ready),
    .mst_resp_i       (mst_resp_i),
    .mst_resp_valid_i (mst_resp_valid_i),
    .mst_resp_ready_o (mst_resp_ready_o),
    .slv_resp_o       (slv_resp_o),
    .slv_resp_valid_o (slv_resp_valid_o),
    .slv_resp_ready_i (slv_resp_ready_i)
  );

endmodule
